/* dv/audio_gain_sva.sv */
// ======================================================================
// Audio gain stage assertions
// Reset behavior, fixed sample latency and output hold of the top level
// ======================================================================

`timescale 1ns/1ns

`include "gain_consts.svh"

module audio_gain_sva (
    input logic               clk,
    input logic               reset,
    input logic               l_r_clk,
    input audio_pkg::sample_t audio_out,
    input logic               out_strobe
);

    // Edges from a sampled l_r_clk change to out_strobe over the MAC stages and the mixer
    localparam int STROBE_DELAY = `MAC_LATENCY + 1;

    // Number of assertion failures so far
    int assert_failures = 0;

    // Quiet through reset and the first cycle after it
    a_strobe_quiet_in_reset: assert property (
        @(posedge clk) reset |=> !out_strobe
    ) else begin
        $error("out_strobe high during or right after reset");
        assert_failures++;
    end

    // Each toggle gives its pulse a fixed number of edges later
    a_edge_to_strobe: assert property (
        @(posedge clk) disable iff (reset)
        $changed(l_r_clk) |-> ##STROBE_DELAY out_strobe
    ) else begin
        $error("out_strobe missing after an l_r_clk change");
        assert_failures++;
    end

    // Output only moves with its pulse
    a_output_hold: assert property (
        @(posedge clk) disable iff (reset)
        !out_strobe |-> $stable(audio_out)
    ) else begin
        $error("audio_out changed without out_strobe");
        assert_failures++;
    end

endmodule

bind audio_gain_top audio_gain_sva u_sva (
    .clk        (clk),
    .reset      (reset),
    .l_r_clk    (l_r_clk),
    .audio_out  (audio_out),
    .out_strobe (out_strobe)
);

/* dv/audio_gain_tb.sv */
// ======================================================================
// Audio gain stage testbench
// Directed tests of the Q2.14 wet gain, saturation, bypass and
// back-to-back samples, checked against a reference gain model
// ======================================================================

`timescale 1ns/1ns

`include "gain_consts.svh"

module audio_gain_tb;

    import audio_pkg::*;

    // The tests take a few hundred cycles, so this leaves a wide margin
    localparam int MAX_CYCLES  = 2000;
    // out_strobe is due four edges after a toggle
    localparam int STROBE_WAIT = 8;
    localparam int BURST_LEN   = 6;

    // Saturation limits of a 16-bit sample
    localparam sample_t SAT_HI = 32767;
    localparam sample_t SAT_LO = -32768;

    logic    clk;
    logic    reset;
    logic    l_r_clk;
    sample_t audio_in;
    coef_t   gain_coef;
    logic    bypass;
    sample_t audio_out;
    logic    out_strobe;

    int cycle_count;
    int error_count;
    int check_count;
    int test_count;
    int errors_before;

    audio_gain_top DUT (
        .clk        (clk),
        .reset      (reset),
        .l_r_clk    (l_r_clk),
        .audio_in   (audio_in),
        .gain_coef  (gain_coef),
        .bypass     (bypass),
        .audio_out  (audio_out),
        .out_strobe (out_strobe)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // Reference gain from the full product, shifted down by the fraction bits
    // with floor and clamped to the 16-bit range
    function automatic sample_t expected_gain(sample_t s, coef_t g, logic byp);
        longint prod;
        longint scaled;
        if (byp) begin
            return s;
        end
        prod   = longint'(s) * longint'(g);
        scaled = prod >>> `COEF_FRAC;
        if (scaled > 32767) begin
            scaled = 32767;
        end else if (scaled < -32768) begin
            scaled = -32768;
        end
        return sample_t'(scaled);
    endfunction

    // One sample per toggle, then wait for its output pulse
    task automatic send_sample(input sample_t s, input coef_t g, input logic byp,
                               input sample_t exp_val);
        bit seen;
        seen = 1'b0;
        @(posedge clk);
        #2;
        audio_in  = s;
        gain_coef = g;
        bypass    = byp;
        l_r_clk   = ~l_r_clk;
        for (int i = 0; i < STROBE_WAIT && !seen; i++) begin
            @(posedge clk);
            #1;
            seen = out_strobe;
        end
        check_count++;
        assert (seen) else begin
            $display("No output strobe within %0d cycles for sample %0d", STROBE_WAIT, s);
            error_count++;
        end
        if (seen) begin
            assert (audio_out === exp_val) else begin
                $display("Error at %0t ns: sample %0d gain %0d bypass %0b gave %0d, expected %0d",
                         $time, s, g, byp, audio_out, exp_val);
                error_count++;
            end
        end
    endtask

    task automatic send_modeled(input sample_t s, input coef_t g, input logic byp);
        send_sample(s, g, byp, expected_gain(s, g, byp));
    endtask

    task automatic start_test();
        errors_before = error_count;
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: passed", test_count, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", test_count, name,
                     error_count - errors_before);
        end
    endtask

    // Output cleared and quiet while l_r_clk is held
    task automatic idle_after_reset();
        int strobes;
        strobes = 0;
        check_count++;
        assert (audio_out === '0) else begin
            $display("Error at %0t ns: audio_out is %0d after reset, expected 0",
                     $time, audio_out);
            error_count++;
        end
        repeat (10) begin
            @(posedge clk);
            #1;
            if (out_strobe) strobes++;
        end
        check_count++;
        assert (strobes == 0) else begin
            $display("Output strobe appeared %0d times with l_r_clk held", strobes);
            error_count++;
        end
    endtask

    // Gain of 0.5 where odd negatives check the floor of the bit slice
    task automatic half_gain_both_edges();
        send_modeled(1000, 8192, 1'b0);
        send_modeled(-1000, 8192, 1'b0);
        send_modeled(3, 8192, 1'b0);
        send_modeled(-3, 8192, 1'b0);
        send_modeled(32767, 8192, 1'b0);
        send_modeled(-32768, 8192, 1'b0);
        send_modeled(1, 8192, 1'b0);
        send_modeled(-1, 8192, 1'b0);
    endtask

    task automatic unity_and_random_gain();
        sample_t s;
        coef_t   g;
        // Unity gain passes the sample unchanged
        for (int i = 0; i < 20; i++) begin
            s = sample_t'($urandom);
            send_sample(s, `UNITY_GAIN, 1'b0, s);
        end
        for (int i = 0; i < 20; i++) begin
            s = sample_t'($urandom);
            g = coef_t'($urandom);
            send_modeled(s, g, 1'b0);
        end
    endtask

    task automatic full_scale_saturation();
        send_sample(32767, 32767, 1'b0, SAT_HI);
        send_sample(-32768, 32767, 1'b0, SAT_LO);
        send_sample(-32768, -32768, 1'b0, SAT_HI);
        send_sample(20000, 32767, 1'b0, SAT_HI);
        send_sample(-20000, 32767, 1'b0, SAT_LO);
    endtask

    task automatic bypass_then_wet();
        send_sample(12345, 8192, 1'b1, 12345);
        send_sample(-20000, 32767, 1'b1, -20000);
        send_sample(-7, -16384, 1'b1, -7);
        // Wet result back once bypass drops
        send_modeled(12345, 8192, 1'b0);
        send_modeled(-7, -16384, 1'b0);
    endtask

    // A new sample on every cycle with outputs collected in arrival order
    task automatic back_to_back_burst();
        sample_t s_q[$];
        coef_t   g_q[$];
        sample_t got_q[$];
        sample_t exp_val;
        for (int i = 0; i < BURST_LEN; i++) begin
            s_q.push_back(sample_t'($urandom));
            g_q.push_back(coef_t'($urandom));
        end
        @(posedge clk);
        #2;
        bypass = 1'b0;
        for (int i = 0; i < BURST_LEN + STROBE_WAIT; i++) begin
            if (i < BURST_LEN) begin
                audio_in  = s_q[i];
                gain_coef = g_q[i];
                l_r_clk   = ~l_r_clk;
            end
            @(posedge clk);
            #1;
            if (out_strobe) got_q.push_back(audio_out);
            #1;
        end
        check_count++;
        assert (got_q.size() == BURST_LEN) else begin
            $display("Got %0d output strobes for %0d back-to-back samples",
                     got_q.size(), BURST_LEN);
            error_count++;
        end
        for (int i = 0; i < got_q.size() && i < BURST_LEN; i++) begin
            exp_val = expected_gain(s_q[i], g_q[i], 1'b0);
            check_count++;
            assert (got_q[i] === exp_val) else begin
                $display("Error at %0t ns: burst output %0d is %0d, expected %0d",
                         $time, i, got_q[i], exp_val);
                error_count++;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        l_r_clk     = 1'b0;
        audio_in    = '0;
        gain_coef   = '0;
        bypass      = 1'b0;
        cycle_count = 0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        // Seeds the generator once for the whole run
        void'($urandom(52661));

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        start_test();
        idle_after_reset();
        report_test("reset and idle");
        start_test();
        half_gain_both_edges();
        report_test("half gain on both edges");
        start_test();
        unity_and_random_gain();
        report_test("unity and random gain");
        start_test();
        full_scale_saturation();
        report_test("saturation");
        start_test();
        bypass_then_wet();
        report_test("bypass");
        start_test();
        back_to_back_burst();
        report_test("back-to-back samples");

        error_count += DUT.u_sva.assert_failures;
        $display("Tests run: %0d, checks: %0d, errors: %0d",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+verilog
verilog/audio_pkg.sv
verilog/mac_pkg.sv
verilog/mac16_accum.sv
verilog/mac_gain_lane.sv
verilog/dry_sample_aligner.sv
verilog/output_mixer.sv
verilog/audio_gain_top.sv
dv/audio_gain_sva.sv
dv/audio_gain_tb.sv

/* verilog/audio_gain_top.sv */
// ======================================================================
// Audio gain stage top
// Mono gain of one sample per l_r_clk toggle: wet MAC lane, matching
// dry path and the output mixer with bypass
// ======================================================================

`timescale 1ns/1ns

module audio_gain_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               l_r_clk,
    input  audio_pkg::sample_t audio_in,
    input  audio_pkg::coef_t   gain_coef,
    input  logic               bypass,
    output audio_pkg::sample_t audio_out,
    output logic               out_strobe
);

    import audio_pkg::*;
    import mac_pkg::*;

    // Edge strobe shared by both paths
    logic    sample_edge;
    // Wet result, valid when aligned_strobe is high
    acc_t    acc;
    // Raw sample delayed to match acc
    sample_t dry_sample;
    logic    aligned_strobe;

    mac_gain_lane u_lane (
        .clk         (clk),
        .reset       (reset),
        .l_r_clk     (l_r_clk),
        .audio_in    (audio_in),
        .gain_coef   (gain_coef),
        .sample_edge (sample_edge),
        .acc         (acc)
    );

    dry_sample_aligner u_dry (
        .clk            (clk),
        .reset          (reset),
        .sample_edge    (sample_edge),
        .audio_in       (audio_in),
        .dry_sample     (dry_sample),
        .aligned_strobe (aligned_strobe)
    );

    // out_strobe follows an l_r_clk change by four clock edges
    output_mixer u_mix (
        .clk            (clk),
        .reset          (reset),
        .acc            (acc),
        .dry_sample     (dry_sample),
        .aligned_strobe (aligned_strobe),
        .bypass         (bypass),
        .audio_out      (audio_out),
        .out_strobe     (out_strobe)
    );

endmodule

/* verilog/audio_pkg.sv */
// ======================================================================
// Audio datapath types
// Sample and gain coefficient words used across the gain stage
// ======================================================================

`include "gain_consts.svh"

package audio_pkg;

    // One mono audio sample
    // Treated as Q1.15 on the dry path and as a Q2.14 result on the wet path
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // Run-time gain coefficient in Q2.14
    // Range is -2.0 up to just under +2.0
    typedef logic signed [`COEF_W-1:0] coef_t;

    // Values of note for coef_t
    //   16384 is unity gain
    //   8192 halves the sample
    //   32767 is the largest positive gain

endpackage

/* verilog/dry_sample_aligner.sv */
// ======================================================================
// Dry sample aligner
// Captures the raw sample on each sample edge and delays it, with its
// strobe, to line up with the MAC accumulator
// ======================================================================

`timescale 1ns/1ns

`include "gain_consts.svh"

module dry_sample_aligner (
    input  logic               clk,
    input  logic               reset,
    input  logic               sample_edge,
    input  audio_pkg::sample_t audio_in,
    output audio_pkg::sample_t dry_sample,
    output logic               aligned_strobe
);

    import audio_pkg::*;

    // One slot per MAC stage, so several samples can be in flight
    sample_t                 sample_pipe [`MAC_LATENCY];
    logic [`MAC_LATENCY-1:0] strobe_pipe;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MAC_LATENCY; i++) begin
                sample_pipe[i] <= '0;
            end
            strobe_pipe <= '0;
        end else begin
            // First stage matches the MAC operand registers
            if (sample_edge) begin
                sample_pipe[0] <= audio_in;
            end
            for (int i = 1; i < `MAC_LATENCY; i++) begin
                sample_pipe[i] <= sample_pipe[i-1];
            end
            strobe_pipe <= {strobe_pipe[`MAC_LATENCY-2:0], sample_edge};
        end
    end

    // Last stage is valid in the same cycle as the loaded accumulator
    assign dry_sample     = sample_pipe[`MAC_LATENCY-1];
    assign aligned_strobe = strobe_pipe[`MAC_LATENCY-1];

endmodule

/* verilog/gain_consts.svh */
// ======================================================================
// Gain stage constants
// Widths, Q2.14 fraction position, MAC pipeline depth and unity gain
// shared by the audio gain datapath and its testbench
// ======================================================================

`ifndef GAIN_CONSTS_SVH
`define GAIN_CONSTS_SVH

// Audio sample width, Q1.15 or Q2.14 depending on use
`define SAMPLE_W 16

// Gain coefficient width, always Q2.14
`define COEF_W 16

// Accumulator width of the DSP-style MAC
`define ACC_W 32

// Fraction bits of a Q2.14 coefficient
`define COEF_FRAC 14

// Cycles from MAC input capture to a loaded accumulator
`define MAC_LATENCY 3

// 1.0 in Q2.14
`define UNITY_GAIN 16384

`endif

/* verilog/mac16_accum.sv */
// ======================================================================
// 16x16 multiply-accumulate unit
// Three-stage signed MAC in the style of an FPGA DSP slice: registered
// inputs, registered product and a loadable 32-bit accumulator
// ======================================================================

`timescale 1ns/1ns

module mac16_accum (
    input  logic               clk,
    input  logic               reset,
    input  logic               ce,
    input  logic               load,
    input  audio_pkg::sample_t a_in,
    input  audio_pkg::coef_t   b_in,
    output mac_pkg::acc_t      result
);

    import audio_pkg::*;
    import mac_pkg::*;

    // Stage 1 operand registers, like A_REG and B_REG
    sample_t  a_q;
    coef_t    b_q;
    logic     ce_q1;
    logic     load_q1;

    // Stage 2 product register, like M_REG
    product_t prod_q;
    logic     ce_q2;
    logic     load_q2;

    // Stage 3 accumulator, like P_REG
    acc_t     acc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            a_q     <= '0;
            b_q     <= '0;
            ce_q1   <= 1'b0;
            load_q1 <= 1'b0;
            prod_q  <= '0;
            ce_q2   <= 1'b0;
            load_q2 <= 1'b0;
            acc_q   <= '0;
        end else begin
            // Operands only move when the caller enables this cycle
            if (ce) begin
                a_q <= a_in;
                b_q <= b_in;
            end
            // Controls ride with their operands down the pipe
            ce_q1   <= ce;
            load_q1 <= load;
            ce_q2   <= ce_q1;
            load_q2 <= load_q1;

            // Both operands sign-extended to the full product width
            if (ce_q1) begin
                prod_q <= product_t'(a_q) * product_t'(b_q);
            end

            // Tagged product either restarts the sum or adds to it
            if (ce_q2) begin
                if (load_q2) acc_q <= acc_t'(prod_q);
                else         acc_q <= acc_q + acc_t'(prod_q);
            end
        end
    end

    assign result = acc_q;

endmodule

/* verilog/mac_gain_lane.sv */
// ======================================================================
// Wet gain lane
// Detects each toggle of the left/right sample clock and runs one
// multiply of the sample by the gain coefficient per toggle
// ======================================================================

`timescale 1ns/1ns

module mac_gain_lane (
    input  logic               clk,
    input  logic               reset,
    input  logic               l_r_clk,
    input  audio_pkg::sample_t audio_in,
    input  audio_pkg::coef_t   gain_coef,
    output logic               sample_edge,
    output mac_pkg::acc_t      acc
);

    // Registered copy of the sample clock level
    // Clears to zero, which also sets the first reference level
    logic l_r_clk_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            l_r_clk_q <= 1'b0;
        end else begin
            l_r_clk_q <= l_r_clk;
        end
    end

    // Any edge of l_r_clk, left or right channel slot alike
    // High for exactly the cycle in which the new level is first seen
    assign sample_edge = l_r_clk ^ l_r_clk_q;

    // One product per sample
    //   ce   captures audio_in and gain_coef at the end of the edge cycle
    //   load makes that product replace the accumulator
    // So acc holds sample times gain, three cycles after capture
    mac16_accum u_mac (
        .clk    (clk),
        .reset  (reset),
        .ce     (sample_edge),
        .load   (sample_edge),
        .a_in   (audio_in),
        .b_in   (gain_coef),
        .result (acc)
    );

    // Nothing else is held here
    // The strobe goes out so the dry path reuses this detection

endmodule

/* verilog/mac_pkg.sv */
// ======================================================================
// Multiply-accumulate datapath types
// Product and accumulator words of the 16x16 DSP-style MAC
// ======================================================================

`include "gain_consts.svh"

package mac_pkg;

    // Full-precision signed product of a sample and a coefficient
    // Q1.15 times Q2.14 lands as Q3.29, Q2.14 times Q2.14 as Q4.28
    typedef logic signed [`SAMPLE_W+`COEF_W-1:0] product_t;

    // Accumulator word
    // Same width as the product here, so a single tap never wraps
    typedef logic signed [`ACC_W-1:0] acc_t;

    // Notes on use
    //   The gain lane loads one product per sample
    //   Summing several taps would need guard bits above the product
    //   which is left for a filter that needs it

endpackage

/* verilog/output_mixer.sv */
// ======================================================================
// Output mixer
// Rescales the accumulator to Q2.14, saturates it to 16 bits, picks
// wet or dry by the bypass level and registers the output pulse
// ======================================================================

`timescale 1ns/1ns

`include "gain_consts.svh"

module output_mixer (
    input  logic               clk,
    input  logic               reset,
    input  mac_pkg::acc_t      acc,
    input  audio_pkg::sample_t dry_sample,
    input  logic               aligned_strobe,
    input  logic               bypass,
    output audio_pkg::sample_t audio_out,
    output logic               out_strobe
);

    import audio_pkg::*;

    // Result window in the accumulator, bits 29 down to 14
    localparam int WET_LSB = `COEF_FRAC;
    localparam int WET_MSB = `COEF_FRAC + `SAMPLE_W - 1;

    // Saturation limits of a 16-bit sample
    localparam sample_t SAT_MAX = {1'b0, {(`SAMPLE_W-1){1'b1}}};
    localparam sample_t SAT_MIN = {1'b1, {(`SAMPLE_W-1){1'b0}}};

    logic [`ACC_W-WET_MSB-1:0] head_bits;
    logic                      overflow;
    sample_t                   wet_sample;

    // Bits above the window plus its sign bit must all agree
    assign head_bits = acc[`ACC_W-1:WET_MSB];
    assign overflow  = ~((&head_bits) | ~(|head_bits));

    // Clamp by the accumulator sign, otherwise plain truncation
    // Truncation rounds toward minus infinity
    always_comb begin
        if (overflow) begin
            wet_sample = acc[`ACC_W-1] ? SAT_MIN : SAT_MAX;
        end else begin
            wet_sample = acc[WET_MSB:WET_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            audio_out  <= '0;
            out_strobe <= 1'b0;
        end else begin
            // Output holds between samples
            if (aligned_strobe) begin
                audio_out <= bypass ? dry_sample : wet_sample;
            end
            out_strobe <= aligned_strobe;
        end
    end

endmodule
